// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall
TOP       := tb_openadc_regs
RTL_TOP   := openadc_regs
FILELIST  := openadc_regs.f
OBJ_DIR   := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "TB PASSED"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== openadc_regs.f ====
rtl/openadc_pkg.sv
rtl/reg_addr_decode.sv
rtl/interval_fifo.sv
rtl/trigger_interval_counter.sv
rtl/openadc_regfile.sv
rtl/readback_mux.sv
rtl/openadc_regs.sv
tests/tb_openadc_regs.sv

// ==== rtl/interval_fifo.sv ====
`default_nettype none

module interval_fifo import openadc_pkg::*; (
   input  logic                   reset,
   input  logic                   adc_sampleclk,
   input  logic                   wr_i,
   input  logic                   rd_i,
   input  logic [TRIG_FIFO_W-1:0] wdata_i,
   output logic [TRIG_FIFO_W-1:0] rdata_o,
   output logic                   empty_o,
   output logic                   full_o,
   output logic                   underflow_o
);

   logic [TRIG_FIFO_W-1:0] mem [TRIG_FIFO_DEPTH];
   logic [TRIG_FIFO_AW:0]  wr_ptr; // extra msb tells full from empty
   logic [TRIG_FIFO_AW:0]  rd_ptr;

   assign empty_o = (wr_ptr == rd_ptr);
   assign full_o  = (wr_ptr[TRIG_FIFO_AW] != rd_ptr[TRIG_FIFO_AW]) &&
                    (wr_ptr[TRIG_FIFO_AW-1:0] == rd_ptr[TRIG_FIFO_AW-1:0]);
   assign rdata_o = mem[rd_ptr[TRIG_FIFO_AW-1:0]]; // head always visible

   always_ff @(posedge adc_sampleclk) begin
      if (reset) begin
         wr_ptr      <= '0;
         rd_ptr      <= '0;
         underflow_o <= 1'b0;
      end else begin
         if (wr_i && !full_o)
            wr_ptr <= wr_ptr + 1'b1;
         if (rd_i) begin
            if (empty_o)
               underflow_o <= 1'b1; // sticky
            else
               rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   always_ff @(posedge adc_sampleclk) begin
      if (wr_i && !full_o)
         mem[wr_ptr[TRIG_FIFO_AW-1:0]] <= wdata_i;
   end

   // pointer distance never passes the depth
   a_occupancy: assert property (@(posedge adc_sampleclk) disable iff (reset)
      (TRIG_FIFO_AW+1)'(wr_ptr - rd_ptr) <= TRIG_FIFO_DEPTH)
      else $error("interval fifo holds more than %0d entries", TRIG_FIFO_DEPTH);

endmodule

`default_nettype wire

// ==== rtl/openadc_pkg.sv ====
`default_nettype none

package openadc_pkg;

   // bus and fifo widths
   localparam int BYTECNT_W       = 3;
   localparam int TRIG_FIFO_W     = 32;
   localparam int TRIG_FIFO_DEPTH = 8;
   localparam int TRIG_FIFO_AW    = $clog2(TRIG_FIFO_DEPTH);

   // register address map
   localparam logic [7:0] ADDR_GAIN        = 8'd0;
   localparam logic [7:0] ADDR_SETTINGS    = 8'd1;
   localparam logic [7:0] ADDR_STATUS      = 8'd2;
   localparam logic [7:0] ADDR_ECHO        = 8'd3;
   localparam logic [7:0] ADDR_SAMPLES     = 8'd4;
   localparam logic [7:0] ADDR_PRESAMPLES  = 8'd5;
   localparam logic [7:0] ADDR_OFFSET      = 8'd6;
   localparam logic [7:0] ADDR_VERSION     = 8'd7;
   localparam logic [7:0] ADDR_MAX_SAMPLES = 8'd8;
   localparam logic [7:0] ADDR_TRIG_LEVEL  = 8'd9;
   localparam logic [7:0] ADDR_TRIG_DATA   = 8'd10;
   localparam logic [7:0] ADDR_TRIG_STAT   = 8'd11;
   localparam logic [7:0] ADDR_RESET       = 8'd12;

   localparam logic [7:0]  SETTINGS_DEFAULT = 8'h24; // rising edge trigger, wait for trigger
   // hw type [15:11], hw version [10:8], register version [3:0]
   localparam logic [15:0] VERSION_WORD     = {5'd8, 3'd1, 4'd0, 4'd2};
   localparam logic [31:0] MAX_SAMPLES      = 32'd24000;
   localparam int          ARM_DELAY        = 4;

   // settings register bits
   localparam int SET_RESET     = 0;
   localparam int SET_TRIG_MODE = 2;
   localparam int SET_ARM       = 3;
   localparam int SET_STREAM    = 4;
   localparam int SET_TRIG_WAIT = 5;
   localparam int SET_TRIG_NOW  = 6;

   typedef struct packed {
      logic [7:0]           address;
      logic [BYTECNT_W-1:0] bytecnt; // byte lane of multi-byte registers
      logic [7:0]           datai;
      logic                 read;
      logic                 write;
   } reg_bus_t;

   // field order puts each select at the bit index of its address
   typedef struct packed {
      logic reset;
      logic trig_stat;
      logic trig_data;
      logic trig_level;
      logic max_samples;
      logic version;
      logic offset;
      logic presamples;
      logic samples;
      logic echo;
      logic status;
      logic settings;
      logic gain;
   } reg_sel_t;

   typedef struct packed {
      logic        mode;
      logic        wait_en;
      logic        now;
      logic [31:0] offset;
      logic [11:0] adclevel;
   } trig_cfg_t;

   typedef struct packed {
      logic [TRIG_FIFO_W-1:0] dout;
      logic                   empty;
      logic                   overflow;
      logic                   underflow;
   } trig_stat_t;

endpackage

`default_nettype wire

// ==== rtl/openadc_regfile.sv ====
`default_nettype none

module openadc_regfile import openadc_pkg::*; (
   input  logic        reset,
   input  logic        adc_sampleclk,
   input  reg_bus_t    bus_i,
   input  reg_sel_t    sel_i,
   output logic [7:0]  gain_o,
   output logic [7:0]  settings_o,
   output logic [63:0] echo_o,
   output logic [31:0] samples_o,
   output logic [14:0] presamples_o,
   output trig_cfg_t   trig_cfg_o,
   output logic        soft_reset_o
);

   logic [31:0]          offset;
   logic [11:0]          adclevel;
   logic                 reset_reg;  // survives its own soft reset
   logic                 core_reset;
   logic [BYTECNT_W-1:0] lane;
   logic                 word_lane;  // lane fits a 32-bit register

   assign lane         = bus_i.bytecnt;
   assign word_lane    = (lane < BYTECNT_W'(4));
   assign soft_reset_o = settings_o[SET_RESET] | reset_reg;
   assign core_reset   = reset | soft_reset_o;

   always_ff @(posedge adc_sampleclk) begin
      if (core_reset) begin
         gain_o       <= 8'h00;
         settings_o   <= SETTINGS_DEFAULT; // also drops the settings soft reset bit
         echo_o       <= '0;
         samples_o    <= MAX_SAMPLES;
         presamples_o <= '0;
         offset       <= '0;
         adclevel     <= '0;
      end else if (bus_i.write) begin
         if (sel_i.gain)
            gain_o <= bus_i.datai;
         if (sel_i.settings)
            settings_o <= bus_i.datai;
         if (sel_i.echo)
            echo_o[lane*8 +: 8] <= bus_i.datai;
         if (sel_i.samples && word_lane)
            samples_o[lane[1:0]*8 +: 8] <= bus_i.datai;
         if (sel_i.offset && word_lane)
            offset[lane[1:0]*8 +: 8] <= bus_i.datai;
         if (sel_i.presamples) begin
            case (lane)
               BYTECNT_W'(0): presamples_o[7:0]  <= bus_i.datai;
               BYTECNT_W'(1): presamples_o[14:8] <= bus_i.datai[6:0];
               default: ;
            endcase
         end
         if (sel_i.trig_level) begin
            case (lane)
               BYTECNT_W'(0): adclevel[7:0]  <= bus_i.datai;
               BYTECNT_W'(1): adclevel[11:8] <= bus_i.datai[3:0];
               default: ;
            endcase
         end
      end
   end

   // only the external reset clears it, so writing 0 is the way out
   always_ff @(posedge adc_sampleclk) begin
      if (reset)
         reset_reg <= 1'b0;
      else if (bus_i.write && sel_i.reset)
         reset_reg <= bus_i.datai[0];
   end

   assign trig_cfg_o.mode     = settings_o[SET_TRIG_MODE];
   assign trig_cfg_o.wait_en  = settings_o[SET_TRIG_WAIT];
   assign trig_cfg_o.now      = settings_o[SET_TRIG_NOW];
   assign trig_cfg_o.offset   = offset;
   assign trig_cfg_o.adclevel = adclevel;

endmodule

`default_nettype wire

// ==== rtl/openadc_regs.sv ====
`default_nettype none

module openadc_regs import openadc_pkg::*; (
   input  logic        adc_sampleclk,
   input  logic        reset,
   input  reg_bus_t    bus_i,
   input  logic [7:0]  status_i,
   input  logic        trigger_event_i,
   output logic [7:0]  reg_datao_o,
   output logic        reset_o,
   output logic [7:0]  gain_o,
   output logic        cmd_arm_usb_o,
   output logic        cmd_arm_adc_o,
   output trig_cfg_t   trig_cfg_o,
   output logic [31:0] samples_o,
   output logic [14:0] presamples_o,
   output logic        fifo_stream_o
);

   reg_sel_t    sel;
   logic        trig_pop;
   logic        trig_clear;
   logic [7:0]  settings;
   logic [63:0] echo;
   logic        soft_reset;
   logic        reset_int;
   trig_stat_t  trig_stat;

   assign reset_int     = reset | soft_reset; // settings bit 0 or reset register
   assign reset_o       = reset_int;
   assign cmd_arm_usb_o = settings[SET_ARM];
   assign fifo_stream_o = settings[SET_STREAM];

   reg_addr_decode u_reg_addr_decode (
      .bus_i        (bus_i),
      .sel_o        (sel),
      .trig_pop_o   (trig_pop),
      .trig_clear_o (trig_clear)
   );

   // regfile takes the external reset so the reset register can hold
   openadc_regfile u_openadc_regfile (
      .reset         (reset),
      .adc_sampleclk (adc_sampleclk),
      .bus_i         (bus_i),
      .sel_i         (sel),
      .gain_o        (gain_o),
      .settings_o    (settings),
      .echo_o        (echo),
      .samples_o     (samples_o),
      .presamples_o  (presamples_o),
      .trig_cfg_o    (trig_cfg_o),
      .soft_reset_o  (soft_reset)
   );

   trigger_interval_counter u_trigger_interval_counter (
      .reset           (reset_int),
      .adc_sampleclk   (adc_sampleclk),
      .arm_i           (cmd_arm_usb_o),
      .trigger_event_i (trigger_event_i),
      .trig_pop_i      (trig_pop),
      .trig_clear_i    (trig_clear),
      .cmd_arm_adc_o   (cmd_arm_adc_o),
      .trig_stat_o     (trig_stat)
   );

   readback_mux u_readback_mux (
      .bus_i        (bus_i),
      .sel_i        (sel),
      .gain_i       (gain_o),
      .settings_i   (settings),
      .echo_i       (echo),
      .samples_i    (samples_o),
      .presamples_i (presamples_o),
      .trig_cfg_i   (trig_cfg_o),
      .status_i     (status_i),
      .trig_stat_i  (trig_stat),
      .reg_datao_o  (reg_datao_o)
   );

endmodule

`default_nettype wire

// ==== rtl/readback_mux.sv ====
`default_nettype none

module readback_mux import openadc_pkg::*; (
   input  reg_bus_t    bus_i,
   input  reg_sel_t    sel_i,
   input  logic [7:0]  gain_i,
   input  logic [7:0]  settings_i,
   input  logic [63:0] echo_i,
   input  logic [31:0] samples_i,
   input  logic [14:0] presamples_i,
   input  trig_cfg_t   trig_cfg_i,
   input  logic [7:0]  status_i,
   input  trig_stat_t  trig_stat_i,
   output logic [7:0]  reg_datao_o
);

   // lanes past the register width read as 0
   function automatic logic [7:0] pick_lane(input logic [63:0] word,
                                            input logic [BYTECNT_W-1:0] lane);
      return word[lane*8 +: 8];
   endfunction

   always_comb begin
      reg_datao_o = 8'h00;
      if (bus_i.read) begin
         case (1'b1)
            sel_i.gain:        reg_datao_o = gain_i;
            sel_i.settings:    reg_datao_o = settings_i;
            sel_i.status:      reg_datao_o = status_i;
            sel_i.echo:        reg_datao_o = pick_lane(echo_i, bus_i.bytecnt);
            sel_i.samples:     reg_datao_o = pick_lane(64'(samples_i), bus_i.bytecnt);
            sel_i.presamples:  reg_datao_o = pick_lane(64'(presamples_i), bus_i.bytecnt);
            sel_i.offset:      reg_datao_o = pick_lane(64'(trig_cfg_i.offset), bus_i.bytecnt);
            sel_i.version:     reg_datao_o = pick_lane(64'(VERSION_WORD), bus_i.bytecnt);
            sel_i.max_samples: reg_datao_o = pick_lane(64'(MAX_SAMPLES), bus_i.bytecnt);
            sel_i.trig_level:  reg_datao_o = pick_lane(64'(trig_cfg_i.adclevel), bus_i.bytecnt);
            sel_i.trig_data:   reg_datao_o = pick_lane(64'(trig_stat_i.dout), bus_i.bytecnt);
            sel_i.trig_stat:   reg_datao_o = {5'b0, trig_stat_i.underflow,
                                              trig_stat_i.overflow, trig_stat_i.empty};
            default: ;  // reset register is write-only
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== rtl/reg_addr_decode.sv ====
`default_nettype none

module reg_addr_decode import openadc_pkg::*; (
   input  reg_bus_t bus_i,
   output reg_sel_t sel_o,
   output logic     trig_pop_o,
   output logic     trig_clear_o
);

   always_comb begin
      sel_o.gain        = (bus_i.address == ADDR_GAIN);
      sel_o.settings    = (bus_i.address == ADDR_SETTINGS);
      sel_o.status      = (bus_i.address == ADDR_STATUS);
      sel_o.echo        = (bus_i.address == ADDR_ECHO);
      sel_o.samples     = (bus_i.address == ADDR_SAMPLES);
      sel_o.presamples  = (bus_i.address == ADDR_PRESAMPLES);
      sel_o.offset      = (bus_i.address == ADDR_OFFSET);
      sel_o.version     = (bus_i.address == ADDR_VERSION);
      sel_o.max_samples = (bus_i.address == ADDR_MAX_SAMPLES);
      sel_o.trig_level  = (bus_i.address == ADDR_TRIG_LEVEL);
      sel_o.trig_data   = (bus_i.address == ADDR_TRIG_DATA);
      sel_o.trig_stat   = (bus_i.address == ADDR_TRIG_STAT);
      sel_o.reset       = (bus_i.address == ADDR_RESET);
   end

   // host reads the head entry, then writes the data register to pop it
   assign trig_pop_o   = bus_i.write & sel_o.trig_data;
   assign trig_clear_o = bus_i.write & sel_o.trig_stat; // any write clears overflow

endmodule

`default_nettype wire

// ==== rtl/trigger_interval_counter.sv ====
`default_nettype none

module trigger_interval_counter import openadc_pkg::*; (
   input  logic       reset,
   input  logic       adc_sampleclk,
   input  logic       arm_i,
   input  logic       trigger_event_i,
   input  logic       trig_pop_i,
   input  logic       trig_clear_i,
   output logic       cmd_arm_adc_o,
   output trig_stat_t trig_stat_o
);

   logic [ARM_DELAY-1:0]   arm_pipe;
   logic                   arm_r;
   logic                   arm_rise;
   logic                   trig_r;
   logic                   trig_edge;
   logic [TRIG_FIFO_W-1:0] count;
   logic                   overflow;
   logic                   flush;
   logic                   fifo_wr;
   logic                   fifo_rd;
   logic                   fifo_full;
   logic                   fifo_empty;
   logic                   fifo_underflow;
   logic [TRIG_FIFO_W-1:0] fifo_dout;

   assign cmd_arm_adc_o = arm_pipe[ARM_DELAY-1];
   assign arm_rise      = cmd_arm_adc_o & ~arm_r;
   assign trig_edge     = trigger_event_i & ~trig_r;
   assign fifo_wr       = trig_edge & ~fifo_full; // lost when full
   assign fifo_rd       = trig_pop_i | (flush & ~fifo_empty);

   always_ff @(posedge adc_sampleclk) begin
      if (reset) begin
         arm_pipe <= '0;
         arm_r    <= 1'b0;
         trig_r   <= 1'b0;
         count    <= '0;
         overflow <= 1'b0;
         flush    <= 1'b0;
      end else begin
         arm_pipe <= {arm_pipe[ARM_DELAY-2:0], arm_i};
         arm_r    <= cmd_arm_adc_o;
         trig_r   <= trigger_event_i;

         // restart at 1 so the stored value is the edge-to-edge distance
         if (fifo_wr)
            count <= TRIG_FIFO_W'(1);
         else if (count != '1)
            count <= count + 1'b1; // saturate

         if (fifo_empty)
            flush <= 1'b0;
         else if (arm_rise)
            flush <= 1'b1;

         if (trig_clear_i || arm_rise)
            overflow <= 1'b0;
         else if (trig_edge && fifo_full)
            overflow <= 1'b1;
      end
   end

   interval_fifo u_interval_fifo (
      .reset         (reset),
      .adc_sampleclk (adc_sampleclk),
      .wr_i          (fifo_wr),
      .rd_i          (fifo_rd),
      .wdata_i       (count),
      .rdata_o       (fifo_dout),
      .empty_o       (fifo_empty),
      .full_o        (fifo_full),
      .underflow_o   (fifo_underflow)
   );

   assign trig_stat_o = '{dout: fifo_dout, empty: fifo_empty,
                          overflow: overflow, underflow: fifo_underflow};

endmodule

`default_nettype wire

// ==== tests/tb_openadc_regs.sv ====
`default_nettype none

module tb_openadc_regs import openadc_pkg::*; ();

   localparam int N_INTERVALS    = 6;
   localparam int MAX_GAP        = 40;
   // edges, arm flush and 4-byte readouts, with a margin of five
   localparam int RUN_ESTIMATE   = (N_INTERVALS + 4) * (MAX_GAP + 10) + 100;
   localparam int TIMEOUT_CYCLES = 5 * RUN_ESTIMATE;

   logic        adc_sampleclk;
   logic        reset;
   reg_bus_t    bus;
   logic [7:0]  status_in;
   logic        trigger_event;
   logic [7:0]  reg_datao;
   logic        reset_out;
   logic [7:0]  gain;
   logic        cmd_arm_usb;
   logic        cmd_arm_adc;
   trig_cfg_t   trig_cfg;
   logic [31:0] samples;
   logic [14:0] presamples;
   logic        fifo_stream;

   int          errors;
   int          errors_at_start;
   int          tests_run;
   int          tests_ok;
   int          cycles;
   logic [31:0] rng_state;
   int          exp_q[$];  // expected intervals in FIFO order

   openadc_regs u_openadc_regs (
      .adc_sampleclk   (adc_sampleclk),
      .reset           (reset),
      .bus_i           (bus),
      .status_i        (status_in),
      .trigger_event_i (trigger_event),
      .reg_datao_o     (reg_datao),
      .reset_o         (reset_out),
      .gain_o          (gain),
      .cmd_arm_usb_o   (cmd_arm_usb),
      .cmd_arm_adc_o   (cmd_arm_adc),
      .trig_cfg_o      (trig_cfg),
      .samples_o       (samples),
      .presamples_o    (presamples),
      .fifo_stream_o   (fifo_stream)
   );

   initial begin
      adc_sampleclk = 1'b0;
      forever #2 adc_sampleclk = ~adc_sampleclk;
   end

   initial begin
      cycles = 0;
      while (cycles < TIMEOUT_CYCLES) begin
         @(posedge adc_sampleclk);
         cycles++;
      end
      $display("timeout: test sequence still running after %0d cycles", cycles);
      $display("TB FAILED");
      $finish;
   end

   // control outputs go quiet one cycle after any reset
   a_reset_quiet: assert property (@(posedge adc_sampleclk)
      reset_out |=> (!cmd_arm_adc && !cmd_arm_usb && !trig_cfg.now))
      else begin
         $display("Error at %0t: arm outputs after reset adc %b usb %b now %b, expected 0",
                  $time, cmd_arm_adc, cmd_arm_usb, trig_cfg.now);
         errors++;
      end

   // adc arm rises exactly ARM_DELAY cycles behind the usb arm
   a_arm_delay: assert property (@(posedge adc_sampleclk) disable iff (reset_out)
      $rose(cmd_arm_adc) |-> ($past(cmd_arm_usb, ARM_DELAY) &&
                              !$past(cmd_arm_usb, ARM_DELAY + 1)))
      else begin
         $display("Error at %0t: cmd_arm_adc_o rose without usb arm %0d cycles earlier",
                  $time, ARM_DELAY);
         errors++;
      end

   function automatic logic [31:0] lcg_next(input logic [31:0] state);
      return state * 32'd1664525 + 32'd1013904223;
   endfunction

   task automatic next_random(output logic [31:0] r);
      rng_state = lcg_next(rng_state);
      r = rng_state;
   endtask

   task automatic check_eq(input string name, input logic [63:0] got,
                           input logic [63:0] exp);
      a_value: assert (got === exp)
         else begin
            $display("Error at %0t: %s = %0h, expected %0h", $time, name, got, exp);
            errors++;
         end
   endtask

   task automatic write_reg(input logic [7:0] addr, input int nbytes,
                            input logic [63:0] data);
      for (int i = 0; i < nbytes; i++) begin
         @(negedge adc_sampleclk);
         bus.address = addr;
         bus.bytecnt = BYTECNT_W'(i);
         bus.datai   = data[i*8 +: 8];
         bus.write   = 1'b1;
      end
      @(negedge adc_sampleclk);
      bus.write = 1'b0;
   endtask

   task automatic read_reg(input logic [7:0] addr, input int nbytes,
                           output logic [63:0] data);
      data = '0;
      for (int i = 0; i < nbytes; i++) begin
         @(negedge adc_sampleclk);
         bus.address = addr;
         bus.bytecnt = BYTECNT_W'(i);
         bus.read    = 1'b1;
         #1;  // mid low phase, comb read settled
         data[i*8 +: 8] = reg_datao;
      end
      @(negedge adc_sampleclk);
      bus.read = 1'b0;
   endtask

   task automatic check_reg(input string name, input logic [7:0] addr, input int nbytes,
                            input logic [63:0] exp);
      logic [63:0] val;
      read_reg(addr, nbytes, val);
      check_eq(name, val, exp);
   endtask

   // one-cycle trigger pulse, stamp is the cycle count at its edge
   task automatic fire_edge(input int gap, output int stamp);
      repeat (gap - 1) @(negedge adc_sampleclk);
      trigger_event = 1'b1;
      stamp = cycles;
      @(negedge adc_sampleclk);
      trigger_event = 1'b0;
   endtask

   task automatic finish_test(input string name);
      tests_run++;
      if (errors == errors_at_start) begin
         tests_ok++;
         $display("test %s: ok", name);
      end else begin
         $display("test %s: %0d errors", name, errors - errors_at_start);
      end
      errors_at_start = errors;
   endtask

   initial begin
      logic [63:0] val;
      logic [63:0] echo_data;
      logic [31:0] r;
      int          stamp;
      int          last_edge;
      int          exp_val;

      rng_state       = 32'h5fe8;
      errors          = 0;
      errors_at_start = 0;
      tests_run       = 0;
      tests_ok        = 0;
      bus             = '0;
      status_in       = 8'h5a;
      trigger_event   = 1'b0;
      reset           = 1'b1;
      repeat (2) @(posedge adc_sampleclk);
      @(negedge adc_sampleclk);
      reset = 1'b0;

      check_reg("reg_datao_o settings", ADDR_SETTINGS, 1, 64'h24);
      check_reg("reg_datao_o gain", ADDR_GAIN, 1, 64'h0);
      check_reg("reg_datao_o version", ADDR_VERSION, 2, 64'(VERSION_WORD));
      check_reg("reg_datao_o max_samples", ADDR_MAX_SAMPLES, 4, 64'(MAX_SAMPLES));
      check_reg("reg_datao_o status", ADDR_STATUS, 1, 64'(status_in));
      check_eq("cmd_arm_adc_o", 64'(cmd_arm_adc), 64'h0);
      check_eq("fifo_stream_o", 64'(fifo_stream), 64'h0);
      check_eq("trig_cfg_o.mode", 64'(trig_cfg.mode), 64'h1);
      check_eq("trig_cfg_o.wait_en", 64'(trig_cfg.wait_en), 64'h1);
      finish_test("reset defaults");

      next_random(r);
      echo_data[31:0] = r;
      next_random(r);
      echo_data[63:32] = r;
      write_reg(ADDR_ECHO, 8, echo_data);
      check_reg("reg_datao_o echo", ADDR_ECHO, 8, echo_data);
      next_random(r);
      write_reg(ADDR_OFFSET, 4, 64'(r));
      check_reg("reg_datao_o offset", ADDR_OFFSET, 4, 64'(r));
      check_eq("trig_cfg_o.offset", 64'(trig_cfg.offset), 64'(r));
      next_random(r);
      write_reg(ADDR_SAMPLES, 4, 64'(r));
      check_eq("samples_o", 64'(samples), 64'(r));
      next_random(r);
      write_reg(ADDR_PRESAMPLES, 2, 64'(r[15:0]));
      check_eq("presamples_o", 64'(presamples), 64'(r[14:0]));
      check_reg("reg_datao_o presamples", ADDR_PRESAMPLES, 2, 64'(r[14:0]));
      next_random(r);
      write_reg(ADDR_TRIG_LEVEL, 2, 64'(r[15:0]));
      check_eq("trig_cfg_o.adclevel", 64'(trig_cfg.adclevel), 64'(r[11:0]));
      check_reg("reg_datao_o trig_level", ADDR_TRIG_LEVEL, 2, 64'(r[11:0]));
      check_reg("reg_datao_o unmapped 0d", 8'h0d, 1, 64'h0);
      check_reg("reg_datao_o unmapped ff", 8'hff, 1, 64'h0);
      finish_test("multi-byte writes");

      write_reg(ADDR_SETTINGS, 1, 64'h18);  // arm and stream, ends one half cycle past the write edge
      check_eq("cmd_arm_usb_o", 64'(cmd_arm_usb), 64'h1);
      check_eq("cmd_arm_adc_o", 64'(cmd_arm_adc), 64'h0);
      check_eq("fifo_stream_o", 64'(fifo_stream), 64'h1);
      check_eq("trig_cfg_o.mode", 64'(trig_cfg.mode), 64'h0);
      check_eq("trig_cfg_o.wait_en", 64'(trig_cfg.wait_en), 64'h0);
      repeat (ARM_DELAY - 1) begin
         @(negedge adc_sampleclk);
         check_eq("cmd_arm_adc_o", 64'(cmd_arm_adc), 64'h0);
      end
      @(negedge adc_sampleclk);
      check_eq("cmd_arm_adc_o", 64'(cmd_arm_adc), 64'h1);
      finish_test("arm delay");

      write_reg(ADDR_SETTINGS, 1, 64'h24);
      for (int k = 0; k < TRIG_FIFO_DEPTH; k++)
         fire_edge(10, last_edge);  // entries for the flush to remove
      fire_edge(10, stamp);  // fifo full, dropped
      check_reg("reg_datao_o trig_stat before arm", ADDR_TRIG_STAT, 1, 64'h2);
      write_reg(ADDR_SETTINGS, 1, 64'h2c);
      while (!cmd_arm_adc)
         @(negedge adc_sampleclk);
      val = '0;
      while (val[0] == 1'b0)
         read_reg(ADDR_TRIG_STAT, 1, val);
      check_eq("reg_datao_o trig_stat after flush", val, 64'h1);
      for (int k = 0; k < N_INTERVALS; k++) begin
         next_random(r);
         fire_edge(5 + int'(r[23:16] % 8'd36), stamp);
         exp_q.push_back(stamp - last_edge);
         last_edge = stamp;
      end
      while (exp_q.size() > 0) begin
         exp_val = exp_q.pop_front();
         read_reg(ADDR_TRIG_DATA, 4, val);
         check_eq("reg_datao_o trig interval", val, 64'(exp_val));
         write_reg(ADDR_TRIG_DATA, 1, 64'h0);
      end
      check_reg("reg_datao_o trig_stat drained", ADDR_TRIG_STAT, 1, 64'h1);
      write_reg(ADDR_TRIG_DATA, 1, 64'h0);  // one pop too many
      check_reg("reg_datao_o trig_stat underflow", ADDR_TRIG_STAT, 1, 64'h5);
      finish_test("interval recording");

      for (int k = 0; k < TRIG_FIFO_DEPTH + 2; k++)
         fire_edge(5, stamp);
      check_reg("reg_datao_o trig_stat overflow", ADDR_TRIG_STAT, 1, 64'h6);
      write_reg(ADDR_TRIG_STAT, 1, 64'h0);
      check_reg("reg_datao_o trig_stat cleared", ADDR_TRIG_STAT, 1, 64'h4);
      finish_test("overflow and clear");

      next_random(r);
      write_reg(ADDR_GAIN, 1, 64'(r[7:0] | 8'h01));
      check_eq("gain_o", 64'(gain), 64'(r[7:0] | 8'h01));
      write_reg(ADDR_SETTINGS, 1, 64'h6c);  // trigger now, still armed
      check_eq("trig_cfg_o.now", 64'(trig_cfg.now), 64'h1);
      write_reg(ADDR_RESET, 1, 64'h1);
      @(negedge adc_sampleclk);
      check_eq("reset_o", 64'(reset_out), 64'h1);
      check_eq("gain_o", 64'(gain), 64'h0);
      write_reg(ADDR_RESET, 1, 64'h0);
      check_eq("reset_o", 64'(reset_out), 64'h0);
      check_reg("reg_datao_o settings", ADDR_SETTINGS, 1, 64'h24);
      check_reg("reg_datao_o trig_stat", ADDR_TRIG_STAT, 1, 64'h1);
      finish_test("soft reset");

      $display("tests %0d, ok %0d, failing %0d, errors %0d",
               tests_run, tests_ok, tests_run - tests_ok, errors);
      if (errors == 0)
         $display("TB PASSED");
      else
         $display("TB FAILED");
      $finish;
   end

endmodule

`default_nettype wire
